/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_top
FILELIST = compile.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* compile.f */
source/led_panel_pkg.sv
source/ctrl_cmd_pkg.sv
source/wb_if.sv
source/uart_rx.sv
source/control_module.sv
source/framebuffer.sv
source/framebuffer_fetch.sv
source/matrix_scan.sv
source/led_matrix_top.sv
dv/panel_checker.sv
dv/tb_top.sv

/* dv/panel_checker.sv */
`timescale 1ns/1ps

module panel_checker import led_panel_pkg::*; (
    input  logic                   clk_in,
    input  logic                   rst_n,
    input  rgb_bits_t              rgb_top,
    input  rgb_bits_t              rgb_bottom,
    input  logic [ROW_W-1:0]       row_addr,
    input  logic                   clk_pixel,
    input  logic                   row_latch,
    input  logic                   oe_n,
    input  logic                   model_we,
    input  logic [FB_ADDR_W-1:0]   model_addr,
    input  logic [15:0]            model_data,
    input  rgb_bits_t              rgb_en,
    input  logic [COLOR_DEPTH-1:0] bright_en,
    input  logic                   check_req,
    output int                     err_cnt,
    output int                     checks_done
);

    localparam int FRAME_LINES = PIXEL_HALFHEIGHT * COLOR_DEPTH;

    logic [15:0] model [PIXEL_WIDTH*PIXEL_HEIGHT];
    rgb_bits_t   top_q [PIXEL_WIDTH];
    rgb_bits_t   bot_q [PIXEL_WIDTH];
    int          pix_cnt;
    int          line_cnt;
    int          on_cnt;
    int          last_plane;
    int          phase;         // 0 idle, 1 armed, 2 draining frame, 3 compared frame
    int          line_errs;
    bit          rst_seen;
    bit          reset_bad;
    bit          reset_done;
    bit          lit_seen;      // on-time finished since the last latch

    // plane bit of one stored word with red and blue widened to 6 bits
    // bit 0 of widened red and blue repeats the channel msb
    function automatic rgb_bits_t expect_bits(input logic [15:0] w, input int p);
        logic red_b;
        logic green_b;
        logic blue_b;
        red_b   = (p == 0) ? w[15] : w[10 + p];
        green_b = w[5 + p];
        blue_b  = (p == 0) ? w[4] : w[p - 1];
        if (!bright_en[p])
            return 3'b000;
        return {red_b & rgb_en[2], green_b & rgb_en[1], blue_b & rgb_en[0]};
    endfunction

    task automatic value_error(input string name, input int row, input int col,
                               input int exp_v, input int act_v);
        if (err_cnt < 40)
            $display("error %s row %0d col %0d: expected %h, got %h",
                     name, row, col, exp_v, act_v);
        err_cnt++;
    endtask

    task automatic compare_line(input int row, input int plane);
        rgb_bits_t et;
        rgb_bits_t eb;
        for (int c = 0; c < PIXEL_WIDTH; c++) begin
            et = expect_bits(model[row*PIXEL_WIDTH + c], plane);
            eb = expect_bits(model[(row + PIXEL_HALFHEIGHT)*PIXEL_WIDTH + c], plane);
            if (top_q[c] !== et) begin
                value_error("rgb_top", row, c, et, top_q[c]);
                line_errs++;
            end
            if (bot_q[c] !== eb) begin
                value_error("rgb_bottom", row + PIXEL_HALFHEIGHT, c, eb, bot_q[c]);
                line_errs++;
            end
        end
    endtask

    initial begin
        err_cnt     = 0;
        checks_done = 0;
        phase       = 0;
        rst_seen    = 0;
        reset_bad   = 0;
        reset_done  = 0;
    end

    always @(posedge clk_in) begin
        int plane;
        int row;
        if (model_we)
            model[model_addr] = model_data;
        if (!rst_n) begin
            // values here come from the previous reset edge
            if (rst_seen && (oe_n !== 1'b1 || row_latch !== 1'b0 || clk_pixel !== 1'b0 ||
                             rgb_top !== 3'b0 || rgb_bottom !== 3'b0))
                reset_bad = 1;
            rst_seen = 1;
            line_cnt = 0;
            pix_cnt  = 0;
            on_cnt   = 0;
            lit_seen = 0;
        end else begin
            if (!reset_done) begin
                reset_done = 1;
                if (reset_bad) begin
                    $display("reset: panel outputs were not idle during reset");
                    err_cnt++;
                end else begin
                    $display("reset: outputs idle");
                end
            end
            if (check_req)
                phase = 1;
            if (line_cnt == 0 && !oe_n && on_cnt == 0 && pix_cnt < PIXEL_WIDTH) begin
                $display("oe_n went low before the first line was latched");
                err_cnt++;
            end
            if ((clk_pixel || row_latch) && oe_n !== 1'b1) begin
                $display("oe_n was low while a column shifted or a row latched");
                err_cnt++;
            end
            if (clk_pixel) begin
                if (pix_cnt < PIXEL_WIDTH) begin
                    top_q[pix_cnt] = rgb_top;
                    bot_q[pix_cnt] = rgb_bottom;
                end
                pix_cnt++;
            end
            if (!oe_n) begin
                on_cnt++;
            end else if (on_cnt != 0) begin
                if (on_cnt != (ON_UNIT << last_plane)) begin
                    $display("oe_n was low for %0d cycles on plane %0d, expected %0d",
                             on_cnt, last_plane, ON_UNIT << last_plane);
                    err_cnt++;
                end
                on_cnt   = 0;
                lit_seen = 1;
            end
            if (row_latch) begin
                plane = line_cnt % COLOR_DEPTH;
                row   = (line_cnt / COLOR_DEPTH) % PIXEL_HALFHEIGHT;
                if (pix_cnt != PIXEL_WIDTH) begin
                    $display("line %0d had %0d clk_pixel pulses instead of %0d",
                             line_cnt, pix_cnt, PIXEL_WIDTH);
                    err_cnt++;
                end
                if (line_cnt > 0 && !lit_seen) begin
                    $display("oe_n did not light line %0d before the next latch",
                             line_cnt - 1);
                    err_cnt++;
                end
                lit_seen = 0;
                if (row_addr !== ROW_W'(row))
                    value_error("row_addr", row, 0, row, row_addr);
                if (phase == 3)
                    compare_line(row, plane);
                last_plane = plane;
                pix_cnt    = 0;
                line_cnt++;
                if (line_cnt % FRAME_LINES == 0) begin
                    if (phase == 3) begin
                        checks_done++;
                        if (line_errs == 0)
                            $display("check %0d: frame matches model", checks_done);
                        else
                            $display("check %0d: %0d mismatches", checks_done, line_errs);
                        phase = 0;
                    end else if (phase != 0) begin
                        phase     = phase + 1;  // next full frame is the one compared
                        line_errs = 0;
                    end
                end
            end
        end
    end

endmodule

/* dv/panel_patterns.txt */
# kind a b c (hex) W: write pixel x y rgb565, R: rgb enable, B: plane enable
# F: random fill rows a..b, S: opcode a with a bad stop bit, C: check a frame
W 00 00 ffff
W 3f 00 f800
W 00 1f 07e0
W 3f 1f 001f
W 05 03 a5c3
W 12 13 5a3c
W 20 0f 8421
W 21 10 7bde
C 1
F 06 07
C 2
R 5
S 01
C 3
R 7
B 2d
C 4
B 3f
C 5

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top import led_panel_pkg::*, ctrl_cmd_pkg::*; ();

    localparam int CMD_CYCLES   = 5 * 12 * TICKS_PER_BIT + 8;  // longest command plus gaps
    localparam int FRAME_CYCLES = PIXEL_HALFHEIGHT * (COLOR_DEPTH * (PIXEL_WIDTH * 8 + 8) +
                                  ON_UNIT * ((1 << COLOR_DEPTH) - 1));

    logic                   clk_in;
    logic                   rst_n;
    logic                   uart_rxd;
    rgb_bits_t              rgb_top;
    rgb_bits_t              rgb_bottom;
    logic [ROW_W-1:0]       row_addr;
    logic                   clk_pixel;
    logic                   row_latch;
    logic                   oe_n;
    logic                   model_we;
    logic [FB_ADDR_W-1:0]   model_addr;
    logic [15:0]            model_data;
    rgb_bits_t              rgb_en;
    logic [COLOR_DEPTH-1:0] bright_en;
    logic                   check_req;
    int                     err_cnt;
    int                     checks_done;
    int                     limit;
    bit                     limit_ready;
    integer                 seed;

    byte unsigned kinds [$];
    int           arg_a [$];
    int           arg_b [$];
    int           arg_c [$];

    led_matrix_top dut_i (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .uart_rxd   (uart_rxd),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .row_addr   (row_addr),
        .clk_pixel  (clk_pixel),
        .row_latch  (row_latch),
        .oe_n       (oe_n)
    );

    panel_checker checker_i (
        .clk_in (clk_in), .rst_n (rst_n),
        .rgb_top (rgb_top), .rgb_bottom (rgb_bottom), .row_addr (row_addr),
        .clk_pixel (clk_pixel), .row_latch (row_latch), .oe_n (oe_n),
        .model_we (model_we), .model_addr (model_addr), .model_data (model_data),
        .rgb_en (rgb_en), .bright_en (bright_en), .check_req (check_req),
        .err_cnt (err_cnt), .checks_done (checks_done)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    task automatic hold_bit(input logic v);
        uart_rxd <= v;
        repeat (TICKS_PER_BIT) @(posedge clk_in);
    endtask

    // 8N1 frame, lsb first, two idle bits after
    task automatic send_byte(input logic [7:0] b, input logic stop_bit);
        @(posedge clk_in);
        hold_bit(1'b0);
        for (int i = 0; i < 8; i++)
            hold_bit(b[i]);
        hold_bit(stop_bit);
        hold_bit(1'b1);
        hold_bit(1'b1);
    endtask

    task automatic write_pixel(input int x, input int y, input logic [15:0] data);
        send_byte(CMD_WRITE_PIXEL, 1'b1);
        send_byte(8'(x), 1'b1);
        send_byte(8'(y), 1'b1);
        send_byte(data[15:8], 1'b1);
        send_byte(data[7:0], 1'b1);
        model_we   <= 1'b1;
        model_addr <= FB_ADDR_W'(y * PIXEL_WIDTH + x);
        model_data <= data;
        @(posedge clk_in);
        model_we <= 1'b0;
    endtask

    task automatic run_check(input int id);
        check_req <= 1'b1;
        @(posedge clk_in);
        check_req <= 1'b0;
        while (checks_done < id)
            @(posedge clk_in);
    endtask

    initial begin
        wait (limit_ready);
        repeat (limit) @(posedge clk_in);
        $display("watchdog: run did not finish within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int    fd;
        int    rv;
        int    a;
        int    b;
        int    c;
        int    n_cmd;
        int    n_fill;
        int    n_check;
        string line;
        rst_n       = 1'b0;
        uart_rxd    = 1'b1;
        model_we    = 1'b0;
        model_addr  = '0;
        model_data  = '0;
        rgb_en      = '1;
        bright_en   = '1;
        check_req   = 1'b0;
        limit_ready = 0;
        seed        = 32'h3f34;
        n_cmd       = 0;
        n_fill      = 0;
        n_check     = 0;
        fd = $fopen("dv/panel_patterns.txt", "r");
        if (fd == 0)
            $display("could not open dv/panel_patterns.txt");
        while (fd != 0 && !$feof(fd)) begin
            rv = $fgets(line, fd);
            if (rv != 0 && line.len() > 2 && line.getc(0) != "#") begin
                a = 0;
                b = 0;
                c = 0;
                rv = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, b, c);
                kinds.push_back(line.getc(0));
                arg_a.push_back(a);
                arg_b.push_back(b);
                arg_c.push_back(c);
                if (line.getc(0) == "C")
                    n_check++;
                else if (line.getc(0) == "F")
                    n_fill += (b - a + 1) * PIXEL_WIDTH;
                else
                    n_cmd++;
            end
        end
        if (fd != 0)
            $fclose(fd);
        limit = (n_cmd + n_fill) * CMD_CYCLES + n_check * 3 * FRAME_CYCLES + FRAME_CYCLES;
        limit_ready = 1;

        repeat (2) @(posedge clk_in);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk_in);

        for (int i = 0; i < kinds.size(); i++) begin
            case (kinds[i])
                "W": write_pixel(arg_a[i], arg_b[i], 16'(arg_c[i]));
                "F": begin
                    for (int y = arg_a[i]; y <= arg_b[i]; y++)
                        for (int x = 0; x < PIXEL_WIDTH; x++)
                            write_pixel(x, y, 16'($random(seed)));
                end
                "R": begin
                    send_byte(CMD_SET_RGB_EN, 1'b1);
                    send_byte(8'(arg_a[i]), 1'b1);
                    rgb_en <= 3'(arg_a[i]);
                end
                "B": begin
                    send_byte(CMD_SET_BRIGHT_EN, 1'b1);
                    send_byte(8'(arg_a[i]), 1'b1);
                    bright_en <= COLOR_DEPTH'(arg_a[i]);
                end
                "S": begin
                    // dropped opcode, so the zero byte after it is not an argument
                    send_byte(8'(arg_a[i]), 1'b0);
                    send_byte(8'h00, 1'b1);
                end
                "C": run_check(checks_done + 1);
                default: $display("unknown pattern line kind %c skipped", kinds[i]);
            endcase
        end

        $display("tests %0d, errors %0d", checks_done + 1, err_cnt);
        if (err_cnt == 0 && checks_done == n_check && fd != 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* source/control_module.sv */
`timescale 1ns/1ps

module control_module import led_panel_pkg::*, ctrl_cmd_pkg::*; (
    input  logic                   clk_in,
    input  logic                   rst_n,
    input  logic [7:0]             rx_data,
    input  logic                   rx_valid,
    output rgb_bits_t              rgb_enable,
    output logic [COLOR_DEPTH-1:0] brightness_enable,
    wb_if.master                   wb
);

    logic                       in_cmd;     // opcode taken, collecting args
    logic [7:0]                 opcode;
    logic [WRITE_ARG_CNT_W-1:0] arg_cnt;
    logic [COL_W-1:0]           pix_x;
    logic [ROW_W:0]             pix_y;      // full panel height
    logic                       cyc;
    logic [1:0]                 sel;
    logic [15:0]                dat_w;

    assign wb.cyc   = cyc;
    assign wb.stb   = cyc;
    assign wb.we    = cyc;                  // write-only master
    assign wb.adr   = {pix_y, pix_x};
    assign wb.sel   = sel;
    assign wb.dat_w = dat_w;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            in_cmd            <= 1'b0;
            arg_cnt           <= '0;
            cyc               <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            if (wb.ack)
                cyc <= 1'b0;                // cycle ends right after ack
            if (rx_valid && !in_cmd) begin
                opcode  <= rx_data;
                arg_cnt <= '0;
                case (rx_data)
                    CMD_SET_RGB_EN, CMD_SET_BRIGHT_EN, CMD_WRITE_PIXEL: in_cmd <= 1'b1;
                    default: in_cmd <= 1'b0;    // unknown opcode, skip it
                endcase
            end else if (rx_valid) begin
                arg_cnt <= arg_cnt + 1'b1;
                case (opcode)
                    CMD_SET_RGB_EN: begin
                        rgb_enable <= rx_data[2:0];
                        in_cmd     <= 1'b0;
                    end
                    CMD_SET_BRIGHT_EN: begin
                        brightness_enable <= rx_data[COLOR_DEPTH-1:0];
                        in_cmd            <= 1'b0;
                    end
                    CMD_WRITE_PIXEL: begin
                        if (arg_cnt == 2'd0) begin
                            pix_x <= rx_data[COL_W-1:0];
                        end else if (arg_cnt == 2'd1) begin
                            pix_y <= rx_data[ROW_W:0];
                        end else begin
                            // one lane per byte, high byte first
                            cyc   <= 1'b1;
                            sel   <= (arg_cnt == 2'd2) ? 2'b10 : 2'b01;
                            dat_w <= {rx_data, rx_data};
                            if (arg_cnt == 2'd3)
                                in_cmd <= 1'b0;
                        end
                    end
                    default: in_cmd <= 1'b0;
                endcase
            end
        end
    end

endmodule

/* source/ctrl_cmd_pkg.sv */
package ctrl_cmd_pkg;

    // opcodes on the control link
    localparam logic [7:0] CMD_SET_RGB_EN    = 8'h01;  // 1 arg, bits 2:0
    localparam logic [7:0] CMD_SET_BRIGHT_EN = 8'h02;  // 1 arg, bits 5:0
    localparam logic [7:0] CMD_WRITE_PIXEL   = 8'h03;  // x, y, hi, lo

    localparam int WRITE_ARG_CNT_W = 2;

    // serial timing, 8N1
    localparam int TICKS_PER_BIT = 4;
    localparam int UART_TICK_W   = $clog2(TICKS_PER_BIT);
    localparam int UART_BIT_W    = 4;                       // start + 8 data + stop

    // index of the stop bit within a frame
    localparam logic [UART_BIT_W-1:0] UART_STOP_IDX = 4'd9;

endpackage

/* source/framebuffer.sv */
`timescale 1ns/1ps

module framebuffer import led_panel_pkg::*; (
    input  logic                 clk_in,
    input  logic                 rst_n,
    wb_if.slave                  wb,
    input  logic [FB_ADDR_W-1:0] rd_addr,
    input  logic                 rd_en,
    output pixel_word_u          rd_data
);

    pixel_word_u mem [PIXEL_WIDTH*PIXEL_HEIGHT];
    pixel_word_u wr_word;
    logic        wr_fire;

    assign wr_word = wb.dat_w;
    // ack stays single-cycle while stb is held
    assign wr_fire = wb.cyc & wb.stb & wb.we & ~wb.ack;

    always_ff @(posedge clk_in) begin
        if (!rst_n)
            wb.ack <= 1'b0;
        else
            wb.ack <= wb.cyc & wb.stb & ~wb.ack;
    end

    // byte-lane write port
    always_ff @(posedge clk_in) begin
        if (wr_fire && wb.sel[1])
            mem[wb.adr].bytes.hi <= wr_word.bytes.hi;
        if (wr_fire && wb.sel[0])
            mem[wb.adr].bytes.lo <= wr_word.bytes.lo;
    end

    always_ff @(posedge clk_in) begin
        if (rd_en)
            rd_data <= mem[rd_addr];    // one cycle latency
    end

endmodule

/* source/framebuffer_fetch.sv */
`timescale 1ns/1ps

module framebuffer_fetch import led_panel_pkg::*; (
    input  logic                   clk_in,
    input  logic                   rst_n,
    input  logic                   load_req,
    input  logic [COL_W-1:0]       col,
    input  logic [ROW_W-1:0]       row,
    input  logic [PLANE_W-1:0]     plane,
    input  rgb_bits_t              rgb_enable,
    input  logic [COLOR_DEPTH-1:0] brightness_enable,
    output logic [FB_ADDR_W-1:0]   rd_addr,
    output logic                   rd_en,
    input  pixel_word_u            rd_data,
    output rgb_bits_t              rgb_top,
    output rgb_bits_t              rgb_bottom,
    output logic                   pix_valid
);

    logic [COL_W-1:0]   col_q;
    logic [ROW_W-1:0]   row_q;
    logic [PLANE_W-1:0] plane_q;
    logic               s1;         // bottom read in flight, top word on rd_data
    logic               s2;         // bottom word on rd_data
    pixel_word_u        top_word;

    // widen to 6 bits and pick the plane bit, then mask
    function automatic rgb_bits_t plane_bits(input rgb565_t px, input logic [PLANE_W-1:0] p,
                                             input rgb_bits_t en,
                                             input logic [COLOR_DEPTH-1:0] pen);
        logic [COLOR_DEPTH-1:0] r6;
        logic [COLOR_DEPTH-1:0] g6;
        logic [COLOR_DEPTH-1:0] b6;
        r6 = {px.red, px.red[4]};
        g6 = px.green;
        b6 = {px.blue, px.blue[4]};
        return {r6[p] & en[2], g6[p] & en[1], b6[p] & en[0]} & {3{pen[p]}};
    endfunction

    // top half first, bottom half is the next 16 rows
    assign rd_en   = load_req | s1;
    assign rd_addr = s1 ? {1'b1, row_q, col_q} : {1'b0, row, col};

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            s1        <= 1'b0;
            s2        <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            s1        <= load_req;
            s2        <= s1;
            pix_valid <= s2;
        end
    end

    always_ff @(posedge clk_in) begin
        if (load_req) begin
            col_q   <= col;
            row_q   <= row;
            plane_q <= plane;
        end
        if (s1)
            top_word <= rd_data;
        if (s2) begin
            rgb_top    <= plane_bits(top_word.rgb, plane_q, rgb_enable, brightness_enable);
            rgb_bottom <= plane_bits(rd_data.rgb, plane_q, rgb_enable, brightness_enable);
        end
    end

endmodule

/* source/led_matrix_top.sv */
`timescale 1ns/1ps

module led_matrix_top import led_panel_pkg::*; (
    input  logic             clk_in,
    input  logic             rst_n,
    input  logic             uart_rxd,
    output rgb_bits_t        rgb_top,
    output rgb_bits_t        rgb_bottom,
    output logic [ROW_W-1:0] row_addr,
    output logic             clk_pixel,
    output logic             row_latch,
    output logic             oe_n
);

    logic [7:0]             rx_data;
    logic                   rx_valid;
    rgb_bits_t              rgb_enable;
    logic [COLOR_DEPTH-1:0] brightness_enable;
    logic [FB_ADDR_W-1:0]   rd_addr;
    logic                   rd_en;
    pixel_word_u            rd_data;
    logic                   load_req;
    logic [COL_W-1:0]       col;
    logic [ROW_W-1:0]       row;
    logic [PLANE_W-1:0]     plane;
    logic                   pix_valid;
    rgb_bits_t              fetch_top;
    rgb_bits_t              fetch_bottom;

    wb_if wb_i ();  // pixel writes, controller to memory

    uart_rx uart_rx_i (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rxd      (uart_rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    control_module ctrl_i (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .wb                (wb_i.master)
    );

    framebuffer fb_i (
        .clk_in  (clk_in),
        .rst_n   (rst_n),
        .wb      (wb_i.slave),
        .rd_addr (rd_addr),
        .rd_en   (rd_en),
        .rd_data (rd_data)
    );

    framebuffer_fetch fetch_i (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .load_req          (load_req),
        .col               (col),
        .row               (row),
        .plane             (plane),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rd_addr           (rd_addr),
        .rd_en             (rd_en),
        .rd_data           (rd_data),
        .rgb_top           (fetch_top),
        .rgb_bottom        (fetch_bottom),
        .pix_valid         (pix_valid)
    );

    matrix_scan scan_i (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .load_req      (load_req),
        .col           (col),
        .row           (row),
        .plane         (plane),
        .pix_valid     (pix_valid),
        .rgb_top_in    (fetch_top),
        .rgb_bottom_in (fetch_bottom),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .row_addr      (row_addr),
        .oe_n          (oe_n)
    );

endmodule

/* source/led_panel_pkg.sv */
package led_panel_pkg;

    // panel geometry
    localparam int PIXEL_WIDTH      = 64;
    localparam int PIXEL_HEIGHT     = 32;
    localparam int PIXEL_HALFHEIGHT = 16;   // rows driven per scan line
    localparam int COL_W            = 6;
    localparam int ROW_W            = 4;
    localparam int FB_ADDR_W        = 11;   // y * width + x

    // colour depth and binary-coded on-time
    localparam int COLOR_DEPTH = 6;
    localparam int PLANE_W     = 3;
    localparam int ON_UNIT     = 8;         // cycles lit for plane 0
    localparam int ON_CNT_W    = 8;         // holds (ON_UNIT << 5) - 1

    // scanner FSM codes
    localparam int SCAN_ST_W = 3;
    localparam logic [SCAN_ST_W-1:0] SCAN_REQ   = 3'd0;
    localparam logic [SCAN_ST_W-1:0] SCAN_WAIT  = 3'd1;
    localparam logic [SCAN_ST_W-1:0] SCAN_SHIFT = 3'd2;
    localparam logic [SCAN_ST_W-1:0] SCAN_NEXT  = 3'd3;
    localparam logic [SCAN_ST_W-1:0] SCAN_LATCH = 3'd4;
    localparam logic [SCAN_ST_W-1:0] SCAN_SHOW  = 3'd5;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // one framebuffer word, seen as colours or as two write lanes
    typedef union packed {
        rgb565_t rgb;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } pixel_word_u;

    typedef logic [2:0] rgb_bits_t;         // [2] red, [1] green, [0] blue

endpackage

/* source/matrix_scan.sv */
`timescale 1ns/1ps

module matrix_scan import led_panel_pkg::*; (
    input  logic               clk_in,
    input  logic               rst_n,
    output logic               load_req,
    output logic [COL_W-1:0]   col,
    output logic [ROW_W-1:0]   row,
    output logic [PLANE_W-1:0] plane,
    input  logic               pix_valid,
    input  rgb_bits_t          rgb_top_in,
    input  rgb_bits_t          rgb_bottom_in,
    output rgb_bits_t          rgb_top,
    output rgb_bits_t          rgb_bottom,
    output logic               clk_pixel,
    output logic               row_latch,
    output logic [ROW_W-1:0]   row_addr,
    output logic               oe_n
);

    logic [SCAN_ST_W-1:0] state;
    logic [ON_CNT_W-1:0]  on_cnt;

    assign load_req = (state == SCAN_REQ);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state      <= SCAN_REQ;
            col        <= '0;
            row        <= '0;
            plane      <= '0;
            on_cnt     <= '0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
            clk_pixel  <= 1'b0;
            row_latch  <= 1'b0;
            row_addr   <= '0;
            oe_n       <= 1'b1;
        end else begin
            case (state)
                SCAN_REQ: state <= SCAN_WAIT;
                SCAN_WAIT: begin
                    if (pix_valid) begin            // fetch latency is not assumed
                        rgb_top    <= rgb_top_in;
                        rgb_bottom <= rgb_bottom_in;
                        state      <= SCAN_SHIFT;
                    end
                end
                SCAN_SHIFT: begin
                    clk_pixel <= 1'b1;              // data already stable
                    state     <= SCAN_NEXT;
                end
                SCAN_NEXT: begin
                    clk_pixel <= 1'b0;
                    if (col == COL_W'(PIXEL_WIDTH - 1)) begin
                        row_latch <= 1'b1;
                        row_addr  <= row;           // address moves with the latch
                        state     <= SCAN_LATCH;
                    end else begin
                        col   <= col + 1'b1;
                        state <= SCAN_REQ;
                    end
                end
                SCAN_LATCH: begin
                    row_latch <= 1'b0;
                    oe_n      <= 1'b0;
                    on_cnt    <= ON_CNT_W'((ON_UNIT << plane) - 1);
                    state     <= SCAN_SHOW;
                end
                SCAN_SHOW: begin
                    if (on_cnt == '0) begin
                        oe_n  <= 1'b1;
                        col   <= '0;
                        state <= SCAN_REQ;
                        // planes first, then rows; row wraps at 16
                        if (plane == PLANE_W'(COLOR_DEPTH - 1)) begin
                            plane <= '0;
                            row   <= row + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        on_cnt <= on_cnt - 1'b1;
                    end
                end
                default: state <= SCAN_REQ;
            endcase
        end
    end

endmodule

/* source/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx import ctrl_cmd_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    logic                  rxd_meta;
    logic                  rxd_sync;
    logic                  busy;
    logic [UART_BIT_W-1:0] bit_idx;    // 0 start, 1..8 data, 9 stop
    logic [UART_TICK_W-1:0] tick;

    // two-flop synchronizer, idles high like the line
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            bit_idx  <= '0;
            tick     <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                if (!rxd_sync) begin            // falling edge of start bit
                    busy    <= 1'b1;
                    bit_idx <= '0;
                    tick    <= UART_TICK_W'(TICKS_PER_BIT / 2 - 1);
                end
            end else if (tick != '0) begin
                tick <= tick - 1'b1;
            end else begin
                // mid-bit sample point
                tick    <= UART_TICK_W'(TICKS_PER_BIT - 1);
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == '0) begin
                    busy <= ~rxd_sync;          // glitch, not a real start
                end else if (bit_idx == UART_STOP_IDX) begin
                    busy     <= 1'b0;
                    rx_valid <= rxd_sync;       // framing error drops the byte
                end else begin
                    rx_data <= {rxd_sync, rx_data[7:1]};  // lsb first
                end
            end
        end
    end

endmodule

/* source/wb_if.sv */
`timescale 1ns/1ps

interface wb_if import led_panel_pkg::*; ();

    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [FB_ADDR_W-1:0] adr;
    logic [1:0]           sel;      // bit 1 selects the high byte
    logic [15:0]          dat_w;
    logic                 ack;

    modport master (
        output cyc, stb, we, adr, sel, dat_w,
        input  ack
    );

    modport slave (
        input  cyc, stb, we, adr, sel, dat_w,
        output ack
    );

endinterface
